//--- project.f
+incdir+src
src/udp_pkg.sv
src/frame_fifo.sv
src/udp_ip_rx.sv
src/udp_checksum_gen.sv
src/udp_ip_tx.sv
src/udp_block.sv
verif/udp_block_checker.sv
verif/udp_block_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the UDP block testbench with Verilator, from the project root
set -e

verilator --binary --timing --assert -f project.f \
    --top-module udp_block_tb -o sim_udp_block

out=$(./obj_dir/sim_udp_block) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "^Test OK$"

//--- src/frame_fifo.sv
// Synchronous FIFO, 2^AW memory entries plus one output register
// A write into an empty FIFO reaches the output on the next edge
module frame_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  AW      = 2
) (
    input  logic   clk,
    input  logic   rst,
    input  entry_t in_data,
    input  logic   in_valid,
    output logic   in_ready,
    output entry_t out_data,
    output logic   out_valid,
    input  logic   out_ready
);

    entry_t      mem [0:(1 << AW) - 1];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        active;
    logic        mem_empty;
    logic        mem_full;
    logic        out_load;
    logic        push;
    logic        pop;
    logic        bypass;

    assign mem_empty = wr_ptr == rd_ptr;
    assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign in_ready  = active && !mem_full;
    assign out_load  = !out_valid || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_load && !mem_empty;
    // Skip the memory when nothing is queued ahead
    assign bypass    = push && out_load && mem_empty;

    always_ff @(posedge clk) begin
        if (push && !bypass) begin
            mem[wr_ptr[AW-1:0]] <= in_data;
        end
        if (pop) begin
            out_data <= mem[rd_ptr[AW-1:0]];
        end else if (bypass) begin
            out_data <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
            active    <= 1'b0;
        end else begin
            active <= 1'b1;
            if (push && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_load) begin
                out_valid <= pop || bypass;
            end
        end
    end

endmodule

//--- src/udp_block.sv
// UDP block for a 64-bit datapath, receive and transmit side by side
// Without checksum generation the transmit header fields are used as given
`include "udp_settings.svh"

module udp_block
    import udp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ip_hdr_t  ip_in_hdr,
    input  logic     ip_in_hdr_valid,
    output logic     ip_in_hdr_ready,
    input  beat_t    ip_in_beat,
    input  logic     ip_in_valid,
    output logic     ip_in_ready,
    output udp_hdr_t udp_out_hdr,
    output logic     udp_out_hdr_valid,
    input  logic     udp_out_hdr_ready,
    output beat_t    udp_out_beat,
    output logic     udp_out_valid,
    input  logic     udp_out_ready,
    input  udp_hdr_t udp_in_hdr,
    input  logic     udp_in_hdr_valid,
    output logic     udp_in_hdr_ready,
    input  beat_t    udp_in_beat,
    input  logic     udp_in_valid,
    output logic     udp_in_ready,
    output ip_hdr_t  ip_out_hdr,
    output logic     ip_out_hdr_valid,
    input  logic     ip_out_hdr_ready,
    output beat_t    ip_out_beat,
    output logic     ip_out_valid,
    input  logic     ip_out_ready,
    output logic     rx_busy,
    output logic     tx_busy,
    output logic     rx_error_early_termination
);

    // Transmit frame between checksum generation and the IP builder
    udp_hdr_t tx_hdr;
    logic     tx_hdr_valid;
    logic     tx_hdr_ready;
    beat_t    tx_beat;
    logic     tx_valid;
    logic     tx_ready;

    udp_ip_rx udp_ip_rx_inst (
        .clk(clk),
        .rst(rst),
        .s_hdr(ip_in_hdr),
        .s_hdr_valid(ip_in_hdr_valid),
        .s_hdr_ready(ip_in_hdr_ready),
        .s_beat(ip_in_beat),
        .s_valid(ip_in_valid),
        .s_ready(ip_in_ready),
        .m_hdr(udp_out_hdr),
        .m_hdr_valid(udp_out_hdr_valid),
        .m_hdr_ready(udp_out_hdr_ready),
        .m_beat(udp_out_beat),
        .m_valid(udp_out_valid),
        .m_ready(udp_out_ready),
        .busy(rx_busy),
        .error_early_termination(rx_error_early_termination)
    );

    generate
        if (`UDP_CHECKSUM_GEN_ENABLE) begin : g_csum
            udp_checksum_gen udp_checksum_gen_inst (
                .clk(clk),
                .rst(rst),
                .s_hdr(udp_in_hdr),
                .s_hdr_valid(udp_in_hdr_valid),
                .s_hdr_ready(udp_in_hdr_ready),
                .s_beat(udp_in_beat),
                .s_valid(udp_in_valid),
                .s_ready(udp_in_ready),
                .m_hdr(tx_hdr),
                .m_hdr_valid(tx_hdr_valid),
                .m_hdr_ready(tx_hdr_ready),
                .m_beat(tx_beat),
                .m_valid(tx_valid),
                .m_ready(tx_ready)
            );
        end else begin : g_direct
            assign tx_hdr           = udp_in_hdr;
            assign tx_hdr_valid     = udp_in_hdr_valid;
            assign udp_in_hdr_ready = tx_hdr_ready;
            assign tx_beat          = udp_in_beat;
            assign tx_valid         = udp_in_valid;
            assign udp_in_ready     = tx_ready;
        end
    endgenerate

    udp_ip_tx udp_ip_tx_inst (
        .clk(clk),
        .rst(rst),
        .s_hdr(tx_hdr),
        .s_hdr_valid(tx_hdr_valid),
        .s_hdr_ready(tx_hdr_ready),
        .s_beat(tx_beat),
        .s_valid(tx_valid),
        .s_ready(tx_ready),
        .m_hdr(ip_out_hdr),
        .m_hdr_valid(ip_out_hdr_valid),
        .m_hdr_ready(ip_out_hdr_ready),
        .m_beat(ip_out_beat),
        .m_valid(ip_out_valid),
        .m_ready(ip_out_ready),
        .busy(tx_busy)
    );

endmodule

//--- src/udp_checksum_gen.sv
// Store-and-forward UDP length and checksum, with the pseudo-header
// A frame must fit in the payload FIFO and carry at least one payload word
// The length and checksum fields of the input header are ignored
`include "udp_settings.svh"

module udp_checksum_gen
    import udp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  udp_hdr_t s_hdr,
    input  logic     s_hdr_valid,
    output logic     s_hdr_ready,
    input  beat_t    s_beat,
    input  logic     s_valid,
    output logic     s_ready,
    output udp_hdr_t m_hdr,
    output logic     m_hdr_valid,
    input  logic     m_hdr_ready,
    output beat_t    m_beat,
    output logic     m_valid,
    input  logic     m_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_SUM,
        ST_FOLD
    } state_t;

    state_t      state;
    udp_hdr_t    hdr_q;
    udp_hdr_t    hdr_done;
    logic [31:0] acc;
    logic [31:0] hdr_sum;
    logic [31:0] sum_q;
    logic [15:0] byte_cnt;
    logic [15:0] udp_len;
    logic [16:0] fold1;
    logic [16:0] fold2;
    logic [15:0] csum;
    logic        hdr_fifo_ready;
    logic        pay_fifo_ready;
    logic        hdr_xfer;
    logic        beat_xfer;

    // 16-bit words of one beat in network order, bytes outside keep as zero
    function automatic logic [17:0] beat_sum(input beat_t b);
        logic [63:0] d;
        logic [17:0] s;
        s = '0;
        for (int i = 0; i < 8; i++) begin
            d[i*8 +: 8] = b.keep[i] ? b.data[i*8 +: 8] : 8'h00;
        end
        for (int i = 0; i < 4; i++) begin
            s = s + 18'({d[i*16 +: 8], d[i*16+8 +: 8]});
        end
        return s;
    endfunction

    function automatic logic [3:0] keep_bytes(input logic [7:0] keep);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + 4'(keep[i]);
        end
        return n;
    endfunction

    assign s_hdr_ready = state == ST_IDLE && hdr_fifo_ready;
    assign s_ready     = state == ST_PAYLOAD && pay_fifo_ready;
    assign hdr_xfer    = s_hdr_valid && s_hdr_ready;
    assign beat_xfer   = s_valid && s_ready;
    assign udp_len     = byte_cnt + 16'd8;

    // Pseudo-header plus ports and length, the length counts twice
    assign hdr_sum = 32'(hdr_q.ip.source_ip[31:16]) + 32'(hdr_q.ip.source_ip[15:0])
                   + 32'(hdr_q.ip.dest_ip[31:16]) + 32'(hdr_q.ip.dest_ip[15:0])
                   + 32'(IP_PROTO_UDP) + 32'(udp_len) + 32'(udp_len)
                   + 32'(hdr_q.source_port) + 32'(hdr_q.dest_port);

    assign fold1 = 17'(sum_q[31:16]) + 17'(sum_q[15:0]);
    assign fold2 = 17'(fold1[15:0]) + 17'(fold1[16]);
    assign csum  = ~fold2[15:0];

    always_comb begin
        hdr_done             = hdr_q;
        hdr_done.ip.protocol = IP_PROTO_UDP;
        hdr_done.ip.length   = udp_len + 16'd20;
        hdr_done.length      = udp_len;
        hdr_done.checksum    = (csum == 16'h0000) ? 16'hFFFF : csum;
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            hdr_q    <= s_hdr;
            acc      <= '0;
            byte_cnt <= '0;
        end
        if (beat_xfer) begin
            acc      <= acc + 32'(beat_sum(s_beat));
            byte_cnt <= byte_cnt + 16'(keep_bytes(s_beat.keep));
        end
        if (state == ST_SUM) begin
            sum_q <= acc + hdr_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_xfer && s_beat.last) begin
                        state <= ST_SUM;
                    end
                end
                ST_SUM: state <= ST_FOLD;
                default: begin
                    if (hdr_fifo_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    frame_fifo #(
        .entry_t(beat_t),
        .AW(`UDP_PAYLOAD_FIFO_AW)
    ) payload_fifo_inst (
        .clk(clk),
        .rst(rst),
        .in_data(s_beat),
        .in_valid(s_valid && state == ST_PAYLOAD),
        .in_ready(pay_fifo_ready),
        .out_data(m_beat),
        .out_valid(m_valid),
        .out_ready(m_ready)
    );

    frame_fifo #(
        .entry_t(udp_hdr_t),
        .AW(`UDP_HEADER_FIFO_AW)
    ) header_fifo_inst (
        .clk(clk),
        .rst(rst),
        .in_data(hdr_done),
        .in_valid(state == ST_FOLD),
        .in_ready(hdr_fifo_ready),
        .out_data(m_hdr),
        .out_valid(m_hdr_valid),
        .out_ready(m_hdr_ready)
    );

endmodule

//--- src/udp_ip_rx.sv
// UDP receive, the first IP payload word is read as the UDP header
// Keep must be full on every word but the last
// A frame that ends in its first word is dropped with an error pulse
module udp_ip_rx
    import udp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ip_hdr_t  s_hdr,
    input  logic     s_hdr_valid,
    output logic     s_hdr_ready,
    input  beat_t    s_beat,
    input  logic     s_valid,
    output logic     s_ready,
    output udp_hdr_t m_hdr,
    output logic     m_hdr_valid,
    input  logic     m_hdr_ready,
    output beat_t    m_beat,
    output logic     m_valid,
    input  logic     m_ready,
    output logic     busy,
    output logic     error_early_termination
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR_WORD,
        ST_PAYLOAD
    } state_t;

    state_t  state;
    ip_hdr_t ip_q;
    logic    active;
    logic    hdr_xfer;
    logic    beat_xfer;
    logic    early;

    // Next header waits until the last word of this frame has left
    assign s_hdr_ready = active && state == ST_IDLE && !m_valid;

    always_comb begin
        case (state)
            ST_HDR_WORD: s_ready = !m_hdr_valid;
            ST_PAYLOAD:  s_ready = !m_valid || m_ready;
            default:     s_ready = 1'b0;
        endcase
    end

    assign hdr_xfer  = s_hdr_valid && s_hdr_ready;
    assign beat_xfer = s_valid && s_ready;
    assign early     = s_beat.last || s_beat.keep != 8'hFF;
    assign busy      = state != ST_IDLE;

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            ip_q <= s_hdr;
        end
        // Network order, byte 0 is the high byte of the source port
        if (state == ST_HDR_WORD && beat_xfer) begin
            m_hdr.ip          <= ip_q;
            m_hdr.source_port <= {s_beat.data[7:0], s_beat.data[15:8]};
            m_hdr.dest_port   <= {s_beat.data[23:16], s_beat.data[31:24]};
            m_hdr.length      <= {s_beat.data[39:32], s_beat.data[47:40]};
            m_hdr.checksum    <= {s_beat.data[55:48], s_beat.data[63:56]};
        end
        if (state == ST_PAYLOAD && beat_xfer) begin
            m_beat <= s_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                   <= ST_IDLE;
            active                  <= 1'b0;
            m_hdr_valid             <= 1'b0;
            m_valid                 <= 1'b0;
            error_early_termination <= 1'b0;
        end else begin
            active                  <= 1'b1;
            error_early_termination <= 1'b0;
            if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
            if (m_ready) begin
                m_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= ST_HDR_WORD;
                    end
                end
                ST_HDR_WORD: begin
                    if (beat_xfer && early) begin
                        error_early_termination <= 1'b1;
                        state                   <= ST_IDLE;
                    end else if (beat_xfer) begin
                        m_hdr_valid <= 1'b1;
                        state       <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_xfer) begin
                        m_valid <= 1'b1;
                        if (s_beat.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- src/udp_ip_tx.sv
// UDP transmit, builds the IP header and puts the UDP header word ahead of the payload
// Every frame carries at least one payload word after the UDP header
module udp_ip_tx
    import udp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  udp_hdr_t s_hdr,
    input  logic     s_hdr_valid,
    output logic     s_hdr_ready,
    input  beat_t    s_beat,
    input  logic     s_valid,
    output logic     s_ready,
    output ip_hdr_t  m_hdr,
    output logic     m_hdr_valid,
    input  logic     m_hdr_ready,
    output beat_t    m_beat,
    output logic     m_valid,
    input  logic     m_ready,
    output logic     busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR_WORD,
        ST_PAYLOAD
    } state_t;

    state_t      state;
    logic [63:0] udp_word;
    logic        active;
    logic        hdr_xfer;
    logic        beat_xfer;
    logic        word_go;

    assign s_hdr_ready = active && state == ST_IDLE && !m_hdr_valid;
    assign s_ready     = state == ST_PAYLOAD && (!m_valid || m_ready);
    assign hdr_xfer    = s_hdr_valid && s_hdr_ready;
    assign beat_xfer   = s_valid && s_ready;
    // Header word goes out once the IP header is taken and the stage is free
    assign word_go     = state == ST_HDR_WORD && !m_hdr_valid && (!m_valid || m_ready);
    assign busy        = state != ST_IDLE;

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            m_hdr          <= s_hdr.ip;
            m_hdr.protocol <= IP_PROTO_UDP;
            m_hdr.length   <= s_hdr.length + 16'd20;
            udp_word       <= {s_hdr.checksum[7:0], s_hdr.checksum[15:8],
                               s_hdr.length[7:0], s_hdr.length[15:8],
                               s_hdr.dest_port[7:0], s_hdr.dest_port[15:8],
                               s_hdr.source_port[7:0], s_hdr.source_port[15:8]};
        end
        if (word_go) begin
            m_beat.data <= udp_word;
            m_beat.keep <= 8'hFF;
            m_beat.last <= 1'b0;
            m_beat.user <= 1'b0;
        end else if (beat_xfer) begin
            m_beat <= s_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            active      <= 1'b0;
            m_hdr_valid <= 1'b0;
            m_valid     <= 1'b0;
        end else begin
            active <= 1'b1;
            if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
            if (m_ready) begin
                m_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        m_hdr_valid <= 1'b1;
                        state       <= ST_HDR_WORD;
                    end
                end
                ST_HDR_WORD: begin
                    if (word_go) begin
                        m_valid <= 1'b1;
                        state   <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_xfer) begin
                        m_valid <= 1'b1;
                        if (s_beat.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- src/udp_pkg.sv
// Header and payload word types shared by the UDP receive and transmit paths
// IP header is fixed at 20 bytes, no options
package udp_pkg;

    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    typedef struct packed {
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        ip_hdr_t     ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // Byte 0 sits in data[7:0]
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } beat_t;

endpackage

//--- src/udp_settings.svh
// Build options for the UDP block
// The payload FIFO must hold a whole frame, since a header leaves only after its last word
`ifndef UDP_SETTINGS_SVH
`define UDP_SETTINGS_SVH

// Checksum payload FIFO address width, in 64-bit words
`define UDP_PAYLOAD_FIFO_AW 5

// Checksum header FIFO address width, sets frames in flight
`define UDP_HEADER_FIFO_AW 2

// 1 puts the checksum generator in the transmit path
`define UDP_CHECKSUM_GEN_ENABLE 1

`endif

//--- verif/udp_block_checker.sv
// Handshake and reset assertions for udp_block, attached by bind
module udp_block_checker
    import udp_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input udp_hdr_t udp_out_hdr,
    input logic     udp_out_hdr_valid,
    input logic     udp_out_hdr_ready,
    input beat_t    udp_out_beat,
    input logic     udp_out_valid,
    input logic     udp_out_ready,
    input ip_hdr_t  ip_out_hdr,
    input logic     ip_out_hdr_valid,
    input logic     ip_out_hdr_ready,
    input beat_t    ip_out_beat,
    input logic     ip_out_valid,
    input logic     ip_out_ready,
    input logic     ip_in_hdr_ready,
    input logic     ip_in_ready,
    input logic     udp_in_hdr_ready,
    input logic     udp_in_ready,
    input logic     rx_busy,
    input logic     tx_busy,
    input logic     rx_error_early_termination
);

    // Valid held with stable data until taken
    assert property (@(posedge clk) disable iff (rst)
        udp_out_hdr_valid && !udp_out_hdr_ready |=> udp_out_hdr_valid && $stable(udp_out_hdr))
        else $error("udp header dropped or changed while stalled");
    assert property (@(posedge clk) disable iff (rst)
        udp_out_valid && !udp_out_ready |=> udp_out_valid && $stable(udp_out_beat))
        else $error("udp beat dropped or changed while stalled");
    assert property (@(posedge clk) disable iff (rst)
        ip_out_hdr_valid && !ip_out_hdr_ready |=> ip_out_hdr_valid && $stable(ip_out_hdr))
        else $error("ip header dropped or changed while stalled");
    assert property (@(posedge clk) disable iff (rst)
        ip_out_valid && !ip_out_ready |=> ip_out_valid && $stable(ip_out_beat))
        else $error("ip beat dropped or changed while stalled");

    assert property (@(posedge clk) rst |=> !udp_out_hdr_valid && !udp_out_valid
        && !ip_out_hdr_valid && !ip_out_valid && !rx_busy && !tx_busy
        && !rx_error_early_termination)
        else $error("outputs not cleared by reset");
    assert property (@(posedge clk) rst && $past(rst) |-> !ip_in_hdr_ready && !ip_in_ready
        && !udp_in_hdr_ready && !udp_in_ready)
        else $error("input ready high during reset");

endmodule

bind udp_block udp_block_checker handshake_checks (.*);

//--- verif/udp_block_tb.sv
// Reads frames from verif/udp_stimulus.txt relative to the project root
// Up to 16 records and 64 beats in total
module udp_block_tb
    import udp_pkg::*;
();

    localparam int MAX_REC  = 16;
    localparam int MAX_BEAT = 64;

    logic clk, rst;
    ip_hdr_t ip_in_hdr, ip_out_hdr;
    udp_hdr_t udp_out_hdr, udp_in_hdr;
    beat_t ip_in_beat, udp_out_beat, udp_in_beat, ip_out_beat;
    logic ip_in_hdr_valid, ip_in_hdr_ready, ip_in_valid, ip_in_ready;
    logic udp_out_hdr_valid, udp_out_hdr_ready, udp_out_valid, udp_out_ready;
    logic udp_in_hdr_valid, udp_in_hdr_ready, udp_in_valid, udp_in_ready;
    logic ip_out_hdr_valid, ip_out_hdr_ready, ip_out_valid, ip_out_ready;
    logic rx_busy, tx_busy, rx_error_early_termination;

    logic [15:0] rec_kind [MAX_REC];
    logic [31:0] rec_src [MAX_REC];
    logic [31:0] rec_dst [MAX_REC];
    logic [15:0] rec_sport [MAX_REC];
    logic [15:0] rec_dport [MAX_REC];
    logic [15:0] rec_exp [MAX_REC][4];
    int          rec_n [MAX_REC];
    int          rec_first [MAX_REC];
    logic [63:0] bt_data [MAX_BEAT];
    logic [7:0]  bt_keep [MAX_BEAT];
    logic        bt_user [MAX_BEAT];
    int n_rec, n_beat, cycles, limit, err_pulses, early_frames;
    int seed;
    logic [31:0] rnd;

    udp_block UUT (.*);

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_stimulus();
        int fd, cnt, left;
        string line;
        fd = $fopen("verif/udp_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/udp_stimulus.txt");
            $display("Test FAILED");
            $fatal(1, "no stimulus");
        end
        left = 0;
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == 8'h23) continue;
            if (left > 0) begin
                cnt = $sscanf(line, "%h %h %h", bt_data[n_beat], bt_keep[n_beat],
                              bt_user[n_beat]);
                n_beat++;
                left--;
            end else begin
                cnt = $sscanf(line, "%s %h %h %h %h %d %h %h %h %h", rec_kind[n_rec],
                              rec_src[n_rec], rec_dst[n_rec], rec_sport[n_rec],
                              rec_dport[n_rec], rec_n[n_rec], rec_exp[n_rec][0],
                              rec_exp[n_rec][1], rec_exp[n_rec][2], rec_exp[n_rec][3]);
                if (cnt != 10) begin
                    $display("Malformed record in the stimulus file: %s", line);
                    $display("Test FAILED");
                    $fatal(1, "bad stimulus");
                end
                if (rec_kind[n_rec] == "rx" && rec_n[n_rec] == 1) early_frames++;
                rec_first[n_rec] = n_beat;
                left = rec_n[n_rec];
                n_rec++;
            end
        end
        $fclose(fd);
    endtask

    function automatic beat_t rec_beat(input int r, input int i);
        beat_t b;
        b.data = bt_data[rec_first[r] + i];
        b.keep = bt_keep[rec_first[r] + i];
        b.last = (i == rec_n[r] - 1);
        b.user = bt_user[rec_first[r] + i];
        return b;
    endfunction

    // Header fields in network order with the first byte in data[7:0]
    function automatic logic [63:0] udp_word(input logic [15:0] sp, input logic [15:0] dp,
                                             input logic [15:0] len, input logic [15:0] cs);
        logic [63:0] be;
        logic [63:0] w;
        be = {sp, dp, len, cs};
        for (int k = 0; k < 8; k++) begin
            w[8*k +: 8] = be[56 - 8*k +: 8];
        end
        return w;
    endfunction

    task automatic drive_rx(input int r);
        ip_hdr_t h;
        h = '0;
        h.version   = 4'd4;
        h.ihl       = 4'd5;
        h.ttl       = 8'd64;
        h.protocol  = IP_PROTO_UDP;
        h.source_ip = rec_src[r];
        h.dest_ip   = rec_dst[r];
        @(negedge clk);
        ip_in_hdr       = h;
        ip_in_hdr_valid = 1'b1;
        do @(posedge clk); while (!ip_in_hdr_ready);
        @(negedge clk);
        ip_in_hdr_valid = 1'b0;
        // Receive FSM waits for the header word now
        check("rx busy", 64'd1, 64'(rx_busy));
        for (int i = 0; i < rec_n[r]; i++) begin
            ip_in_beat  = rec_beat(r, i);
            ip_in_valid = 1'b1;
            do @(posedge clk); while (!ip_in_ready);
            @(negedge clk);
        end
        ip_in_valid = 1'b0;
    endtask

    task automatic drive_tx(input int r);
        udp_hdr_t h;
        h = '0;
        h.ip.ttl       = 8'd64;
        h.ip.source_ip = rec_src[r];
        h.ip.dest_ip   = rec_dst[r];
        h.source_port  = rec_sport[r];
        h.dest_port    = rec_dport[r];
        @(negedge clk);
        udp_in_hdr       = h;
        udp_in_hdr_valid = 1'b1;
        do @(posedge clk); while (!udp_in_hdr_ready);
        @(negedge clk);
        udp_in_hdr_valid = 1'b0;
        for (int i = 0; i < rec_n[r]; i++) begin
            udp_in_beat  = rec_beat(r, i);
            udp_in_valid = 1'b1;
            do @(posedge clk); while (!udp_in_ready);
            @(negedge clk);
        end
        udp_in_valid = 1'b0;
    endtask

    task automatic watch_udp_hdrs();
        for (int r = 0; r < n_rec; r++) begin
            if (rec_kind[r] != "rx" || rec_n[r] < 2) continue;
            do @(posedge clk); while (!(udp_out_hdr_valid && udp_out_hdr_ready));
            check("rx source port", 64'(rec_exp[r][0]), 64'(udp_out_hdr.source_port));
            check("rx dest port", 64'(rec_exp[r][1]), 64'(udp_out_hdr.dest_port));
            check("rx udp length", 64'(rec_exp[r][2]), 64'(udp_out_hdr.length));
            check("rx udp checksum", 64'(rec_exp[r][3]), 64'(udp_out_hdr.checksum));
            check("rx source ip", 64'(rec_src[r]), 64'(udp_out_hdr.ip.source_ip));
            check("rx dest ip", 64'(rec_dst[r]), 64'(udp_out_hdr.ip.dest_ip));
            check("rx ttl", 64'd64, 64'(udp_out_hdr.ip.ttl));
        end
    endtask

    task automatic watch_udp_beats();
        beat_t e;
        for (int r = 0; r < n_rec; r++) begin
            if (rec_kind[r] != "rx") continue;
            for (int i = 1; i < rec_n[r]; i++) begin
                e = rec_beat(r, i);
                do @(posedge clk); while (!(udp_out_valid && udp_out_ready));
                check("rx payload data", e.data, udp_out_beat.data);
                check("rx payload keep last user", 64'({e.keep, e.last, e.user}),
                      64'({udp_out_beat.keep, udp_out_beat.last, udp_out_beat.user}));
            end
        end
    endtask

    task automatic watch_ip_hdrs();
        for (int r = 0; r < n_rec; r++) begin
            if (rec_kind[r] != "tx") continue;
            do @(posedge clk); while (!(ip_out_hdr_valid && ip_out_hdr_ready));
            check("tx ip length", 64'(rec_exp[r][0] + 16'd20), 64'(ip_out_hdr.length));
            check("tx protocol", 64'd17, 64'(ip_out_hdr.protocol));
            check("tx source ip", 64'(rec_src[r]), 64'(ip_out_hdr.source_ip));
            check("tx dest ip", 64'(rec_dst[r]), 64'(ip_out_hdr.dest_ip));
            check("tx ttl", 64'd64, 64'(ip_out_hdr.ttl));
            check("tx busy", 64'd1, 64'(tx_busy));
        end
    endtask

    task automatic watch_ip_beats();
        beat_t e;
        for (int r = 0; r < n_rec; r++) begin
            if (rec_kind[r] != "tx") continue;
            do @(posedge clk); while (!(ip_out_valid && ip_out_ready));
            check("tx udp header word",
                  udp_word(rec_sport[r], rec_dport[r], rec_exp[r][0], rec_exp[r][1]),
                  ip_out_beat.data);
            check("tx header word keep last", 64'h1fe, 64'({ip_out_beat.keep, ip_out_beat.last}));
            for (int i = 0; i < rec_n[r]; i++) begin
                e = rec_beat(r, i);
                do @(posedge clk); while (!(ip_out_valid && ip_out_ready));
                check("tx payload data", e.data, ip_out_beat.data);
                check("tx payload keep last user", 64'({e.keep, e.last, e.user}),
                      64'({ip_out_beat.keep, ip_out_beat.last, ip_out_beat.user}));
            end
        end
    endtask

    // Random back-pressure on all four output channels
    always @(negedge clk) begin
        if (!rst) begin
            rnd = $random(seed);
            udp_out_hdr_ready = rnd[0];
            udp_out_ready     = rnd[1];
            ip_out_hdr_ready  = rnd[2];
            ip_out_ready      = rnd[3];
        end
    end

    always @(posedge clk) begin
        if (!rst && rx_error_early_termination) err_pulses++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'h3e4a;
        ip_in_hdr = '0;
        ip_in_hdr_valid = 1'b0;
        ip_in_beat = '0;
        ip_in_valid = 1'b0;
        udp_in_hdr = '0;
        udp_in_hdr_valid = 1'b0;
        udp_in_beat = '0;
        udp_in_valid = 1'b0;
        udp_out_hdr_ready = 1'b0;
        udp_out_ready = 1'b0;
        ip_out_hdr_ready = 1'b0;
        ip_out_ready = 1'b0;
        cycles = 0;
        err_pulses = 0;
        early_frames = 0;
        n_rec = 0;
        n_beat = 0;
        limit = 100;
        load_stimulus();
        limit = 200 * n_rec + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            begin
                for (int r = 0; r < n_rec; r++) begin
                    if (rec_kind[r] == "rx") begin
                        drive_rx(r);
                    end
                end
            end
            begin
                for (int r = 0; r < n_rec; r++) begin
                    if (rec_kind[r] == "tx") begin
                        drive_tx(r);
                    end
                end
            end
            watch_udp_hdrs();
            watch_udp_beats();
            watch_ip_hdrs();
            watch_ip_beats();
        join
        repeat (4) @(posedge clk);
        check("rx early termination pulses", 64'(early_frames), 64'(err_pulses));
        check("rx busy at end", 64'd0, 64'(rx_busy));
        check("tx busy at end", 64'd0, 64'(tx_busy));
        $display("Test OK");
        $finish;
    end

endmodule

//--- verif/udp_stimulus.txt
# kind src_ip dst_ip src_port dst_port beats exp_a exp_b exp_c exp_d, then one line per beat
# beat line: data keep user; rx exp is port port length checksum, tx exp is length checksum
rx c0a80a01 c0a80a02 0000 0000 3 1234 5678 0018 abcd
cdab180078563412 ff 0
0102030405060708 ff 0
00000000a1a2a3a4 0f 1
rx c0a80a03 c0a80a04 0000 0000 1 0000 0000 0000 0000
1111111111111111 ff 0
rx c0a80a05 c0a80a06 0000 0000 2 0035 0400 0010 0000
0000100000043500 ff 0
1122334455667788 ff 0
tx c0a80001 c0a80002 1234 5678 1 0010 05ba 0000 0000
0807060504030201 ff 0
tx c0a80001 c0a80002 0400 0035 2 0013 f22d 0000 0000
8877665544332211 ff 0
deadbeef00ccbbaa 07 1
tx c0a80001 c0a80002 0007 0009 1 000a 7e76 0000 0000
000000000000ffff 03 0
